/* common/rs_enc_pkg.sv */
`default_nettype none

package rs_enc_pkg;

    localparam int MSG_BYTES    = 168;
    localparam int PARITY_BYTES = 32;
    localparam int CODE_BYTES   = 200;

    localparam logic [8:0] GF_POLY  = 9'h11D;
    localparam logic [7:0] GF_ALPHA = 8'h02;

    typedef logic [7:0] byte_t;

    // Byte k sits at bits 8k+7:8k
    typedef logic [MSG_BYTES-1:0][7:0]  msg_block_t;
    typedef logic [CODE_BYTES-1:0][7:0] codeword_t;

    typedef enum logic [1:0] {
        PH_NONE   = 2'd0,
        PH_MSG    = 2'd1,
        PH_PARITY = 2'd2
    } beat_phase_e;

    typedef enum logic [1:0] {
        LD_IDLE   = 2'd0,
        LD_MSG    = 2'd1,
        LD_PARITY = 2'd2,
        LD_DRAIN  = 2'd3
    } loader_state_e;

    typedef struct packed {
        beat_phase_e phase;
        byte_t       data;  // Zero during parity phase
        logic        last;  // 200th beat of the block
    } enc_beat_t;

    typedef struct packed {
        logic  valid;
        logic  last;
        byte_t data;
    } code_beat_t;

    localparam enc_beat_t IDLE_BEAT = '{phase: PH_NONE, data: 8'h00, last: 1'b0};

    // Shift-and-add multiply, reducing by the field polynomial
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t prod;
        byte_t sh;
        prod = '0;
        sh   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                prod ^= sh;
            sh = sh[7] ? ((sh << 1) ^ GF_POLY[7:0]) : (sh << 1);
        end
        return prod;
    endfunction

    // Coefficient idx of prod (x + alpha^j), j = 0..31
    function automatic byte_t rs_gen_coef(int unsigned idx);
        byte_t g [0:PARITY_BYTES];
        byte_t root;
        for (int k = 0; k <= PARITY_BYTES; k++)
            g[k] = '0;
        g[0] = 8'h01;
        root = 8'h01;
        for (int j = 0; j < PARITY_BYTES; j++) begin
            for (int k = PARITY_BYTES; k > 0; k--)
                g[k] = g[k-1] ^ gf_mul(g[k], root);
            g[0] = gf_mul(g[0], root);
            root = gf_mul(root, GF_ALPHA);
        end
        return g[idx];
    endfunction

endpackage

`default_nettype wire

/* source/rs_block_loader.sv */
`default_nettype none

module rs_block_loader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clrn,
    input  logic                   encode_en,
    input  rs_enc_pkg::msg_block_t datain,
    output rs_enc_pkg::enc_beat_t  beat,
    output logic                   ready
);
    import rs_enc_pkg::*;

    loader_state_e state;
    msg_block_t    hold;
    logic [7:0]    cnt;   // Beat number within the block
    logic          accept;

    assign accept = encode_en && ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LD_IDLE;
            hold  <= '0;
            cnt   <= '0;
            beat  <= IDLE_BEAT;
            ready <= 1'b1;
        end else if (!clrn) begin
            state <= LD_IDLE;
            hold  <= '0;
            cnt   <= '0;
            beat  <= IDLE_BEAT;
            ready <= 1'b1;
        end else begin
            case (state)
                LD_IDLE: begin
                    beat <= IDLE_BEAT;
                    if (accept) begin
                        hold  <= datain;
                        cnt   <= '0;
                        ready <= 1'b0;
                        state <= LD_MSG;
                    end
                end

                LD_MSG: begin
                    // Byte 0 goes first, then the block shifts down
                    beat.phase <= PH_MSG;
                    beat.data  <= hold[0];
                    beat.last  <= 1'b0;
                    hold       <= {8'h00, hold[MSG_BYTES-1:1]};
                    cnt        <= cnt + 8'd1;
                    if (cnt == 8'(MSG_BYTES - 1))
                        state <= LD_PARITY;
                end

                LD_PARITY: begin
                    beat.phase <= PH_PARITY;
                    beat.data  <= 8'h00;
                    beat.last  <= (cnt == 8'(CODE_BYTES - 1));
                    if (cnt == 8'(CODE_BYTES - 1)) begin
                        cnt   <= '0;
                        state <= LD_DRAIN;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end

                LD_DRAIN: begin
                    // Last beat is in the assembler now
                    beat  <= IDLE_BEAT;
                    ready <= 1'b1;
                    state <= LD_IDLE;
                end

                default: begin
                    beat  <= IDLE_BEAT;
                    ready <= 1'b1;
                    state <= LD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rs_parity/rs_parity_lfsr.sv */
`default_nettype none

module rs_parity_lfsr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clrn,
    input  rs_enc_pkg::enc_beat_t  beat,
    output rs_enc_pkg::code_beat_t code
);
    import rs_enc_pkg::*;

    byte_t par [PARITY_BYTES];  // par[31] holds the highest-degree term
    byte_t tap [PARITY_BYTES];
    byte_t fb;

    assign fb = beat.data ^ par[PARITY_BYTES-1];

    // Constant multipliers, one per generator coefficient
    for (genvar i = 0; i < PARITY_BYTES; i++) begin : g_tap
        assign tap[i] = gf_mul(fb, rs_gen_coef(i));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            par <= '{default: 8'h00};
        end else if (!clrn) begin
            par <= '{default: 8'h00};
        end else begin
            case (beat.phase)
                PH_MSG: begin
                    par[0] <= tap[0];
                    for (int i = 1; i < PARITY_BYTES; i++)
                        par[i] <= par[i-1] ^ tap[i];
                end

                PH_PARITY: begin
                    // Shift remainder out, zeros fill from the bottom
                    par[0] <= 8'h00;
                    for (int i = 1; i < PARITY_BYTES; i++)
                        par[i] <= par[i-1];
                end

                default: ;
            endcase
        end
    end

    // Output follows the incoming beat, the assembler registers it
    always_comb begin
        case (beat.phase)
            PH_MSG: begin
                code.valid = 1'b1;
                code.last  = beat.last;
                code.data  = beat.data;
            end

            PH_PARITY: begin
                code.valid = 1'b1;
                code.last  = beat.last;
                code.data  = par[PARITY_BYTES-1];
            end

            default: begin
                code.valid = 1'b0;
                code.last  = 1'b0;
                code.data  = 8'h00;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/rs_codeword_assembler.sv */
`default_nettype none

module rs_codeword_assembler (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clrn,
    input  rs_enc_pkg::code_beat_t code,
    output rs_enc_pkg::codeword_t  encoded_data,
    output logic                   valid
);
    import rs_enc_pkg::*;

    codeword_t  work;    // Block under construction
    codeword_t  merged;
    logic [7:0] idx;

    // Work buffer with the final byte dropped in
    always_comb begin
        merged      = work;
        merged[idx] = code.data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work         <= '0;
            encoded_data <= '0;
            idx          <= '0;
            valid        <= 1'b0;
        end else if (!clrn) begin
            work         <= '0;
            encoded_data <= '0;
            idx          <= '0;
            valid        <= 1'b0;
        end else begin
            valid <= code.valid && code.last;
            if (code.valid) begin
                work[idx] <= code.data;
                if (code.last) begin
                    encoded_data <= merged;  // Output only moves on completion
                    idx          <= '0;
                end else begin
                    idx <= idx + 8'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/rs_encoder_top.sv */
`default_nettype none

module rs_encoder_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clrn,
    input  logic                   encode_en,
    input  rs_enc_pkg::msg_block_t datain,
    output rs_enc_pkg::codeword_t  encoded_data,
    output logic                   valid,
    output logic                   ready
);
    import rs_enc_pkg::*;

    enc_beat_t  beat;
    code_beat_t code;

    rs_block_loader u_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .clrn      (clrn),
        .encode_en (encode_en),
        .datain    (datain),
        .beat      (beat),
        .ready     (ready)
    );

    rs_parity_lfsr u_lfsr (
        .clk   (clk),
        .rst_n (rst_n),
        .clrn  (clrn),
        .beat  (beat),
        .code  (code)
    );

    rs_codeword_assembler u_assembler (
        .clk          (clk),
        .rst_n        (rst_n),
        .clrn         (clrn),
        .code         (code),
        .encoded_data (encoded_data),
        .valid        (valid)
    );

endmodule

`default_nettype wire

/* sim/rs_encoder_sva.sv */
`default_nettype none

module rs_encoder_sva (
    input logic clk,
    input logic rst_n,
    input logic clrn,
    input logic encode_en,
    input logic valid,
    input logic ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic accept;
    int   fail_count = 0;

    assign accept = encode_en && ready && clrn;

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n || !clrn)
        valid |=> !valid)
        else begin
            $error("valid stayed high for two cycles");
            fail_count++;
        end

    a_valid_ready: assert property (@(posedge clk) disable iff (!rst_n || !clrn)
        valid |-> ready)
        else begin
            $error("valid high while ready is low");
            fail_count++;
        end

    a_ready_fall: assert property (@(posedge clk) disable iff (!rst_n || !clrn)
        accept |=> !ready)
        else begin
            $error("ready did not fall after an accept");
            fail_count++;
        end

    // Low for 201 samples before the pulse
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n || !clrn)
        accept |=> (!valid) [*201] ##1 valid)
        else begin
            $error("valid did not rise 201 cycles after an accept");
            fail_count++;
        end

endmodule

bind rs_encoder_top rs_encoder_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .clrn      (clrn),
    .encode_en (encode_en),
    .valid     (valid),
    .ready     (ready)
);

`default_nettype wire

/* sim/rs_encoder_tb.sv */
`default_nettype none

module rs_encoder_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rs_enc_pkg::*;

    localparam int READY_LIMIT = 400;
    localparam int VALID_LIMIT = 300;

    logic        clk;
    logic        rst_n;
    logic        clrn;
    logic        encode_en;
    msg_block_t  datain;
    codeword_t   encoded_data;
    logic        valid;
    logic        ready;

    logic [31:0] lfsr_state;
    byte_t       gen [0:PARITY_BYTES];  // Indexed by degree with gen[32] = 1
    codeword_t   last_cw;               // Value encoded_data must hold
    int          checks;
    int          errors;
    int          timeouts;
    bit          aborted;

    rs_encoder_top u_rs_encoder_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .clrn         (clrn),
        .encode_en    (encode_en),
        .datain       (datain),
        .encoded_data (encoded_data),
        .valid        (valid),
        .ready        (ready)
    );

    always #4 clk = ~clk;

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic byte_t rand_byte();
        byte_t b;
        int    i;
        b = '0;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    function automatic msg_block_t rand_block();
        msg_block_t blk;
        int         i;
        for (i = 0; i < MSG_BYTES; i++)
            blk[i] = rand_byte();
        return blk;
    endfunction

    // Horner form with the MSB of b first
    function automatic byte_t field_mul(byte_t a, byte_t b);
        logic [8:0] p;
        int         i;
        p = '0;
        for (i = 7; i >= 0; i--) begin
            p = p << 1;
            if (p[8])
                p = p ^ GF_POLY;
            if (b[i])
                p = p ^ {1'b0, a};
        end
        return p[7:0];
    endfunction

    task automatic build_generator();
        byte_t root;
        int    i;
        int    j;
        for (i = 0; i <= PARITY_BYTES; i++)
            gen[i] = 8'h00;
        gen[0] = 8'h01;
        root   = 8'h01;
        for (j = 0; j < PARITY_BYTES; j++) begin
            for (i = PARITY_BYTES; i > 0; i--)
                gen[i] = gen[i-1] ^ field_mul(gen[i], root);
            gen[0] = field_mul(gen[0], root);
            root   = field_mul(root, 8'h02);
        end
    endtask

    // Long division of M(x) x^32 by the generator with index 0 at degree 199
    function automatic codeword_t model_codeword(msg_block_t m);
        byte_t     rem [0:CODE_BYTES-1];
        byte_t     lead;
        codeword_t cw;
        int        i;
        int        j;
        for (i = 0; i < CODE_BYTES; i++)
            rem[i] = 8'h00;
        for (i = 0; i < MSG_BYTES; i++)
            rem[i] = m[i];
        for (i = 0; i < MSG_BYTES; i++) begin
            lead = rem[i];
            for (j = 0; j <= PARITY_BYTES; j++)
                rem[i+j] = rem[i+j] ^ field_mul(gen[PARITY_BYTES-j], lead);
        end
        cw = '0;
        for (i = 0; i < MSG_BYTES; i++)
            cw[i] = m[i];
        for (i = MSG_BYTES; i < CODE_BYTES; i++)
            cw[i] = rem[i];
        return cw;
    endfunction

    task automatic check_codeword(input string name, input codeword_t got, input codeword_t want);
        int k;
        int shown;
        checks++;
        shown = 0;
        if (got !== want) begin
            errors++;
            for (k = 0; k < CODE_BYTES; k++) begin
                if (got[k] !== want[k] && shown < 4) begin
                    $display("ERR %s byte %0d got %h expected %h", name, k, got[k], want[k]);
                    shown++;
                end
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic wait_ready(output bit ok);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < READY_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = (ready === 1'b1);
        if (!ok) begin
            aborted = 1'b1;
            timeouts++;
            $display("Timeout: ready did not return within %0d cycles", READY_LIMIT);
        end
    endtask

    // Strobes encode_en while busy when noise is set
    task automatic wait_valid(input bit noise, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 1; n <= VALID_LIMIT; n++) begin
            @(negedge clk);
            encode_en = 1'b0;
            if (valid === 1'b1) begin
                ok = 1'b1;
                break;
            end
            if (n == 100)
                check_codeword("encoded_data", encoded_data, last_cw);
            if (noise && (n % 65 == 4)) begin
                datain    = rand_block();
                encode_en = 1'b1;
            end
        end
        if (!ok) begin
            aborted = 1'b1;
            timeouts++;
            $display("Timeout: valid did not rise within %0d cycles", VALID_LIMIT);
        end
    endtask

    task automatic start_block(input msg_block_t blk, output bit ok);
        wait_ready(ok);
        if (!ok)
            return;
        datain    = blk;
        encode_en = 1'b1;
        @(negedge clk);
        encode_en = 1'b0;
        check_bit("ready", ready, 1'b0);
        check_bit("valid", valid, 1'b0);
    endtask

    task automatic run_block(input msg_block_t blk, input bit noise);
        codeword_t want;
        bit        ok;
        want = model_codeword(blk);
        start_block(blk, ok);
        if (!ok)
            return;
        wait_valid(noise, ok);
        if (!ok)
            return;
        check_bit("ready", ready, 1'b1);
        check_codeword("encoded_data", encoded_data, want);
        last_cw = want;
    endtask

    initial begin
        msg_block_t blk;
        codeword_t  cw;
        bit         ok;
        int         i;
        int         sva_fails;
        clk        = 1'b0;
        rst_n      = 1'b0;
        clrn       = 1'b1;
        encode_en  = 1'b0;
        datain     = '0;
        lfsr_state = 32'ha2cd_5493;
        last_cw    = '0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        aborted    = 1'b0;
        build_generator();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_bit("ready", ready, 1'b1);
        check_bit("valid", valid, 1'b0);
        check_codeword("encoded_data", encoded_data, '0);

        run_block(rand_block(), 1'b0);
        if (!aborted) begin
            @(negedge clk);
            check_bit("valid", valid, 1'b0);  // Single pulse
            check_codeword("encoded_data", encoded_data, last_cw);
        end

        if (!aborted)
            run_block('0, 1'b0);
        if (!aborted)
            check_codeword("encoded_data", encoded_data, '0);

        // Impulse at degree 0 gives the generator as parity
        blk      = '0;
        blk[167] = 8'h01;
        cw       = '0;
        cw[167]  = 8'h01;
        for (i = 0; i < PARITY_BYTES; i++)
            cw[MSG_BYTES+i] = gen[PARITY_BYTES-1-i];
        if (!aborted)
            run_block(blk, 1'b0);
        if (!aborted)
            check_codeword("encoded_data", encoded_data, cw);

        if (!aborted)
            run_block(rand_block(), 1'b1);
        if (!aborted) begin
            repeat (20) @(negedge clk);
            check_bit("ready", ready, 1'b1);
            check_bit("valid", valid, 1'b0);
            check_codeword("encoded_data", encoded_data, last_cw);
        end

        // Abort a block part way through
        if (!aborted)
            start_block(rand_block(), ok);
        if (!aborted) begin
            repeat (80) @(negedge clk);
            clrn = 1'b0;
            @(negedge clk);
            clrn = 1'b1;
            check_bit("ready", ready, 1'b1);
            check_bit("valid", valid, 1'b0);
            check_codeword("encoded_data", encoded_data, '0);
            last_cw = '0;
        end
        if (!aborted)
            run_block(rand_block(), 1'b0);

        for (i = 0; i < 10; i++) begin
            if (!aborted)
                run_block(rand_block(), 1'b0);
        end

        sva_fails = u_rs_encoder_top.u_sva.fail_count;
        $display("Checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, sva_fails);
        if (errors == 0 && timeouts == 0 && sva_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/rs_enc_pkg.sv
source/rs_block_loader.sv
rs_parity/rs_parity_lfsr.sv
source/rs_codeword_assembler.sv
source/rs_encoder_top.sv
sim/rs_encoder_sva.sv
sim/rs_encoder_tb.sv
